//--- hdl/alu_pkg.sv
package alu_pkg;

  localparam int reg_w  = 64;
  localparam int imm_w  = 16;
  localparam int op_w   = 5;
  localparam int mode_w = 2;

  // immediate form is the register form with bit 0 set
  localparam logic [op_w-1:0] op_add   = 5'd0;
  localparam logic [op_w-1:0] op_addi  = 5'd1;
  localparam logic [op_w-1:0] op_sub   = 5'd2;
  localparam logic [op_w-1:0] op_subi  = 5'd3;
  localparam logic [op_w-1:0] op_adc   = 5'd4;
  localparam logic [op_w-1:0] op_adci  = 5'd5;
  localparam logic [op_w-1:0] op_sbb   = 5'd6;
  localparam logic [op_w-1:0] op_sbbi  = 5'd7;
  localparam logic [op_w-1:0] op_and   = 5'd8;
  localparam logic [op_w-1:0] op_andi  = 5'd9;
  localparam logic [op_w-1:0] op_or    = 5'd10;
  localparam logic [op_w-1:0] op_ori   = 5'd11;
  localparam logic [op_w-1:0] op_xor   = 5'd12;
  localparam logic [op_w-1:0] op_xori  = 5'd13;
  localparam logic [op_w-1:0] op_sll   = 5'd14;
  localparam logic [op_w-1:0] op_slli  = 5'd15;
  localparam logic [op_w-1:0] op_mov   = 5'd16;
  localparam logic [op_w-1:0] op_movi  = 5'd17;
  localparam logic [op_w-1:0] op_cmp   = 5'd18;
  localparam logic [op_w-1:0] op_cmpi  = 5'd19;
  localparam logic [op_w-1:0] op_test  = 5'd20;
  localparam logic [op_w-1:0] op_testi = 5'd21;

  localparam logic [mode_w-1:0] mode_8  = 2'd0;
  localparam logic [mode_w-1:0] mode_16 = 2'd1;
  localparam logic [mode_w-1:0] mode_32 = 2'd2;
  localparam logic [mode_w-1:0] mode_64 = 2'd3;

  localparam int flag_cf = 0;
  localparam int flag_pf = 2;
  localparam int flag_af = 4;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

  localparam int queue_depth = 4;
  localparam int out_credits = 2;
  localparam int qptr_w      = $clog2(queue_depth);
  localparam int qcnt_w      = $clog2(queue_depth + 1);
  localparam int ocred_w     = $clog2(out_credits + 1);

  typedef struct packed {
    logic [reg_w-flag_of-2:0]   rsvd_hi;
    logic                       of;
    logic [flag_of-flag_sf-2:0] rsvd_10_8;
    logic                       sf;
    logic                       zf;     // sits right below sf
    logic [flag_zf-flag_af-2:0] rsvd_5;
    logic                       af;
    logic [flag_af-flag_pf-2:0] rsvd_3;
    logic                       pf;
    logic [flag_pf-flag_cf-2:0] rsvd_1;
    logic                       cf;
  } eflags_s;

  typedef union packed {
    logic [reg_w-1:0] raw;
    eflags_s          f;
  } eflags_u;

endpackage

//--- hdl/op_queue.sv
`timescale 1ns/10ps

module op_queue
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              op_valid,
  input  logic [op_w-1:0]   opcode,
  input  logic [mode_w-1:0] mode,
  input  logic [reg_w-1:0]  s,
  input  logic [reg_w-1:0]  t,
  input  logic [imm_w-1:0]  imm,
  input  logic              pop,
  output logic              op_credit,
  output logic              empty,
  output logic [op_w-1:0]   q_opcode,
  output logic [mode_w-1:0] q_mode,
  output logic [reg_w-1:0]  q_s,
  output logic [reg_w-1:0]  q_t,
  output logic [imm_w-1:0]  q_imm
);

  logic [op_w-1:0]   opcode_mem [queue_depth];
  logic [mode_w-1:0] mode_mem   [queue_depth];
  logic [reg_w-1:0]  s_mem      [queue_depth];
  logic [reg_w-1:0]  t_mem      [queue_depth];
  logic [imm_w-1:0]  imm_mem    [queue_depth];

  logic [qptr_w-1:0] wr_ptr;
  logic [qptr_w-1:0] rd_ptr;
  logic [qcnt_w-1:0] count;

  function automatic logic [qptr_w-1:0] next_ptr(input logic [qptr_w-1:0] p);
    return (p == qptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // producer only sends while holding a credit, so no full check
  always_ff @(posedge clk) begin
    if (op_valid) begin
      opcode_mem[wr_ptr] <= opcode;
      mode_mem[wr_ptr]   <= mode;
      s_mem[wr_ptr]      <= s;
      t_mem[wr_ptr]      <= t;
      imm_mem[wr_ptr]    <= imm;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      op_credit <= 1'b0;
    end else begin
      if (op_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({op_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      op_credit <= pop;   // one credit back per released entry
    end
  end

  assign empty    = (count == '0);
  assign q_opcode = opcode_mem[rd_ptr];
  assign q_mode   = mode_mem[rd_ptr];
  assign q_s      = s_mem[rd_ptr];
  assign q_t      = t_mem[rd_ptr];
  assign q_imm    = imm_mem[rd_ptr];

endmodule

//--- hdl/arith_unit.sv
`timescale 1ns/10ps

module arith_unit
  import alu_pkg::*;
(
  input  logic [op_w-1:0]   opcode,
  input  logic [mode_w-1:0] mode,
  input  logic [reg_w-1:0]  s,
  input  logic [reg_w-1:0]  t_sel,
  input  eflags_u           flags_in,
  output logic [reg_w-1:0]  d,
  output eflags_u           flags_out
);

  logic [op_w-2:0]          base;
  logic                     use_cf;
  logic                     negate;
  logic                     is_cmp;
  logic [reg_w-1:0]         t_cf;
  logic [reg_w-1:0]         t_op;
  logic [reg_w:0]           sum;
  logic [reg_w:0]           carries;
  logic [$clog2(reg_w)-1:0] top;
  logic [reg_w-1:0]         mask;
  logic [reg_w-1:0]         res;
  logic                     s_msb;
  logic                     t_msb;
  logic                     r_msb;

  assign base   = opcode[op_w-1:1];
  assign use_cf = (base == op_adc[op_w-1:1]) || (base == op_sbb[op_w-1:1]);
  assign is_cmp = (base == op_cmp[op_w-1:1]);
  assign negate = (base == op_sub[op_w-1:1]) || (base == op_sbb[op_w-1:1]) || is_cmp;

  // sbb folds the carry in before negating
  assign t_cf = t_sel + {{(reg_w-1){1'b0}}, use_cf & flags_in.f.cf};
  assign t_op = negate ? ~t_cf + 1'b1 : t_cf;
  assign sum  = {1'b0, s} + {1'b0, t_op};

  // carry into each bit position
  assign carries = sum ^ {1'b0, s} ^ {1'b0, t_op};

  always_comb begin
    case (mode)
      mode_8:  top = 6'd7;
      mode_16: top = 6'd15;
      mode_32: top = 6'd31;
      default: top = 6'd63;
    endcase
  end

  assign mask  = {reg_w{1'b1}} >> (6'd63 - top);
  assign res   = sum[reg_w-1:0] & mask;
  assign s_msb = s[top];
  assign t_msb = t_op[top];
  assign r_msb = res[top];

  always_comb begin
    flags_out.raw  = flags_in.raw;
    flags_out.f.of = (r_msb & ~s_msb & ~t_msb) | (~r_msb & s_msb & t_msb);
    flags_out.f.sf = r_msb;
    flags_out.f.zf = (res == '0);
    flags_out.f.af = 1'b0;
    flags_out.f.cf = carries[top + 1];  // out of the mode's top bit
    flags_out.f.pf = ~^res;
  end

  assign d = is_cmp ? '0 : res;

endmodule

//--- hdl/logic_unit.sv
`timescale 1ns/10ps

module logic_unit
  import alu_pkg::*;
(
  input  logic [op_w-1:0]   opcode,
  input  logic [mode_w-1:0] mode,
  input  logic [reg_w-1:0]  s,
  input  logic [reg_w-1:0]  t_sel,
  input  eflags_u           flags_in,
  output logic [reg_w-1:0]  d,
  output eflags_u           flags_out
);

  logic [op_w-2:0]  base;
  logic             is_mov;
  logic             is_test;
  logic [reg_w-1:0] raw_res;
  logic [reg_w-1:0] res;
  logic             msb;

  assign base    = opcode[op_w-1:1];
  assign is_mov  = (base == op_mov[op_w-1:1]);
  assign is_test = (base == op_test[op_w-1:1]);

  always_comb begin
    case (base)
      op_and[op_w-1:1],
      op_test[op_w-1:1]: raw_res = s & t_sel;
      op_or[op_w-1:1]:   raw_res = s | t_sel;
      op_xor[op_w-1:1]:  raw_res = s ^ t_sel;
      op_sll[op_w-1:1]:  raw_res = s << t_sel[$clog2(reg_w)-1:0];
      op_mov[op_w-1:1]:  raw_res = t_sel;
      default:           raw_res = '0;
    endcase
  end

  // truncate and zero-extend
  always_comb begin
    case (mode)
      mode_8:  res = reg_w'(raw_res[7:0]);
      mode_16: res = reg_w'(raw_res[15:0]);
      mode_32: res = reg_w'(raw_res[31:0]);
      default: res = raw_res;
    endcase
  end

  always_comb begin
    case (mode)
      mode_8:  msb = raw_res[7];
      mode_16: msb = raw_res[15];
      mode_32: msb = raw_res[31];
      default: msb = raw_res[63];
    endcase
  end

  always_comb begin
    flags_out = flags_in;
    if (!is_mov) begin
      flags_out.f.of = 1'b0;
      flags_out.f.sf = msb;
      flags_out.f.zf = (res == '0);
      flags_out.f.af = 1'b0;
      flags_out.f.cf = 1'b0;
      flags_out.f.pf = ~^res;
    end
  end

  assign d = is_test ? '0 : res;

endmodule

//--- hdl/alu_core.sv
`timescale 1ns/10ps

module alu_core
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              empty,
  input  logic [op_w-1:0]   q_opcode,
  input  logic [mode_w-1:0] q_mode,
  input  logic [reg_w-1:0]  q_s,
  input  logic [reg_w-1:0]  q_t,
  input  logic [imm_w-1:0]  q_imm,
  input  logic              res_credit,
  output logic              pop,
  output logic              res_valid,
  output logic [reg_w-1:0]  d,
  output logic [reg_w-1:0]  eflags
);

  logic [op_w-2:0]    base;
  logic               is_arith;
  logic [reg_w-1:0]   t_sel;
  logic [reg_w-1:0]   arith_d;
  logic [reg_w-1:0]   logic_d;
  eflags_u            arith_flags;
  eflags_u            logic_flags;
  eflags_u            flags_q;
  logic [ocred_w-1:0] credit_cnt;

  // odd opcodes take the immediate
  assign t_sel = q_opcode[0] ? {{(reg_w-imm_w){1'b0}}, q_imm} : q_t;
  assign base  = q_opcode[op_w-1:1];

  always_comb begin
    case (base)
      op_add[op_w-1:1],
      op_sub[op_w-1:1],
      op_adc[op_w-1:1],
      op_sbb[op_w-1:1],
      op_cmp[op_w-1:1]: is_arith = 1'b1;
      default:          is_arith = 1'b0;
    endcase
  end

  assign pop = !empty && (credit_cnt != '0);

  arith_unit u_arith (
    .opcode    (q_opcode),
    .mode      (q_mode),
    .s         (q_s),
    .t_sel     (t_sel),
    .flags_in  (flags_q),
    .d         (arith_d),
    .flags_out (arith_flags)
  );

  logic_unit u_logic (
    .opcode    (q_opcode),
    .mode      (q_mode),
    .s         (q_s),
    .t_sel     (t_sel),
    .flags_in  (flags_q),
    .d         (logic_d),
    .flags_out (logic_flags)
  );

  always_ff @(posedge clk) begin
    if (pop)
      d <= is_arith ? arith_d : logic_d;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid  <= 1'b0;
      flags_q    <= '0;
      credit_cnt <= ocred_w'(out_credits);
    end else begin
      res_valid <= pop;
      if (pop)
        flags_q <= is_arith ? arith_flags : logic_flags;
      // spend on pop, refill on consumer credit
      case ({pop, res_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign eflags = flags_q.raw;

endmodule

//--- hdl/alu_top.sv
`timescale 1ns/10ps

module alu_top
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              op_valid,
  input  logic [op_w-1:0]   opcode,
  input  logic [mode_w-1:0] mode,
  input  logic [reg_w-1:0]  s,
  input  logic [reg_w-1:0]  t,
  input  logic [imm_w-1:0]  imm,
  input  logic              res_credit,
  output logic              op_credit,
  output logic              res_valid,
  output logic [reg_w-1:0]  d,
  output logic [reg_w-1:0]  eflags
);

  logic              pop;
  logic              empty;
  logic [op_w-1:0]   q_opcode;
  logic [mode_w-1:0] q_mode;
  logic [reg_w-1:0]  q_s;
  logic [reg_w-1:0]  q_t;
  logic [imm_w-1:0]  q_imm;

  op_queue u_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_valid  (op_valid),
    .opcode    (opcode),
    .mode      (mode),
    .s         (s),
    .t         (t),
    .imm       (imm),
    .pop       (pop),
    .op_credit (op_credit),
    .empty     (empty),
    .q_opcode  (q_opcode),
    .q_mode    (q_mode),
    .q_s       (q_s),
    .q_t       (q_t),
    .q_imm     (q_imm)
  );

  alu_core u_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .empty      (empty),
    .q_opcode   (q_opcode),
    .q_mode     (q_mode),
    .q_s        (q_s),
    .q_t        (q_t),
    .q_imm      (q_imm),
    .res_credit (res_credit),
    .pop        (pop),
    .res_valid  (res_valid),
    .d          (d),
    .eflags     (eflags)
  );

endmodule

//--- testbench/alu_tb.sv
`timescale 1ns/10ps

module alu_tb
  import alu_pkg::*;
();

  localparam int clk_period    = 20;
  localparam int num_rand      = 200;
  localparam int max_ops       = num_rand + 32;  // random plus directed and held batch
  localparam int cycles_per_op = 24;

  logic              clk        = 1'b0;
  logic              arst_n     = 1'b0;
  logic              op_valid   = 1'b0;
  logic [op_w-1:0]   opcode     = '0;
  logic [mode_w-1:0] mode       = '0;
  logic [reg_w-1:0]  s          = '0;
  logic [reg_w-1:0]  t          = '0;
  logic [imm_w-1:0]  imm        = '0;
  logic              res_credit = 1'b0;
  logic              op_credit;
  logic              res_valid;
  logic [reg_w-1:0]  d;
  logic [reg_w-1:0]  eflags;

  logic [2*reg_w-1:0] exp_q[$];   // {d, flags} per operation, in order
  logic [reg_w-1:0]   model_flags  = '0;
  logic [31:0]        lfsr         = 32'h2d63;
  logic               hold_credits = 1'b0;
  int                 errors        = 0;
  int                 results_seen  = 0;
  int                 owed          = 0;  // result credits not yet returned
  int                 accepted      = 0;
  int                 credit_pulses = 0;
  int                 credits_back  = 0;
  int                 sent_cnt      = 0;

  alu_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .op_valid   (op_valid),
    .opcode     (opcode),
    .mode       (mode),
    .s          (s),
    .t          (t),
    .imm        (imm),
    .res_credit (res_credit),
    .op_credit  (op_credit),
    .res_valid  (res_valid),
    .d          (d),
    .eflags     (eflags)
  );

  always #(clk_period / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] v);
    return {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // returns {d, new flags}
  function automatic logic [2*reg_w-1:0] alu_ref(
    input logic [op_w-1:0]   opc,
    input logic [mode_w-1:0] md,
    input logic [reg_w-1:0]  a,
    input logic [reg_w-1:0]  b_reg,
    input logic [imm_w-1:0]  im,
    input logic [reg_w-1:0]  fl
  );
    logic [reg_w-1:0] b;
    logic [reg_w-1:0] mask;
    logic [reg_w-1:0] r;
    logic [reg_w-1:0] f;
    logic [reg_w:0]   sum;
    logic [op_w-1:0]  kind;
    logic             arith;
    int               w;
    w     = 8 << md;
    mask  = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    b     = opc[0] ? {{(reg_w-imm_w){1'b0}}, im} : b_reg;
    kind  = opc | 5'd1;  // fold both forms onto one code
    f     = fl;
    sum   = '0;
    arith = 1'b0;
    case (kind)
      op_andi, op_testi: r = a & b;
      op_ori:            r = a | b;
      op_xori:           r = a ^ b;
      op_slli:           r = a << b[5:0];
      op_movi:           r = b;
      default: begin
        arith = 1'b1;
        if (kind == op_adci || kind == op_sbbi)
          b = b + 64'(fl[flag_cf]);
        if (kind != op_addi && kind != op_adci)
          b = -b;
        r   = a + b;
        sum = {1'b0, a & mask} + {1'b0, b & mask};
      end
    endcase
    r = r & mask;
    if (kind != op_movi) begin
      f[flag_sf] = r[w-1];
      f[flag_zf] = (r == '0);
      f[flag_pf] = ~^r;
      f[flag_af] = 1'b0;
      f[flag_cf] = arith ? sum[w] : 1'b0;
      f[flag_of] = arith ? (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]) : 1'b0;
    end
    if (kind == op_cmpi || kind == op_testi)
      r = '0;
    return {r, f};
  endfunction

  task automatic check_val(input string what, input logic [reg_w-1:0] got,
                           input logic [reg_w-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic send_op(input logic [op_w-1:0] opc, input logic [mode_w-1:0] md,
                         input logic [reg_w-1:0] a, input logic [reg_w-1:0] b,
                         input logic [imm_w-1:0] im);
    logic [2*reg_w-1:0] e;
    while (sent_cnt - credits_back >= queue_depth) begin
      op_valid <= 1'b0;
      @(posedge clk);
    end
    e           = alu_ref(opc, md, a, b, im, model_flags);
    model_flags = e[reg_w-1:0];
    exp_q.push_back(e);
    op_valid <= 1'b1;
    opcode   <= opc;
    mode     <= md;
    s        <= a;
    t        <= b;
    imm      <= im;
    sent_cnt++;
    @(posedge clk);
  endtask

  task automatic send_random;
    logic [op_w-1:0]   opc;
    logic [mode_w-1:0] md;
    logic [reg_w-1:0]  a;
    logic [reg_w-1:0]  b;
    logic [imm_w-1:0]  im;
    opc = op_w'(rand_bits(5) % 22);
    md  = mode_w'(rand_bits(2));
    a   = rand_bits(64);
    b   = (rand_bits(2) == 0) ? a : rand_bits(64);  // equal operands hit zf
    im  = imm_w'(rand_bits(16));
    send_op(opc, md, a, b, im);
  endtask

  task automatic drain;
    op_valid <= 1'b0;
    do
      @(negedge clk);
    while (exp_q.size() != 0 || owed != 0);
    repeat (3) @(posedge clk);
  endtask

  // compare results and hand credits back to the core
  always @(posedge clk) begin : compare_results
    logic [2*reg_w-1:0] e;
    res_credit <= 1'b0;
    if (arst_n && res_valid) begin
      results_seen++;
      owed++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("a result arrived at %0t with no operation outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_val("d", d, e[2*reg_w-1:reg_w]);
        check_val("eflags", eflags, e[reg_w-1:0]);
      end
    end
    if (!hold_credits && owed > 0) begin
      res_credit <= 1'b1;
      owed--;
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      if (op_valid)
        accepted++;
      if (op_credit)
        credit_pulses++;
      credits_back <= credits_back + int'(op_credit);  // producer view, one edge late
      check_val("outstanding operations out of range",
                64'(accepted < credit_pulses || accepted - credit_pulses > queue_depth),
                64'd0);
    end
  end

  initial begin
    #((max_ops * cycles_per_op + 100) * clk_period);
    $display("timeout: the run did not finish in the time allowed for %0d operations",
             max_ops);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    int held_base;
    int held_n;
    repeat (16) begin
      @(posedge clk);
      check_val("res_valid in reset", 64'(res_valid), 64'd0);
      check_val("op_credit in reset", 64'(op_credit), 64'd0);
    end
    arst_n <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_val("res_valid while idle", 64'(res_valid), 64'd0);
      check_val("op_credit while idle", 64'(op_credit), 64'd0);
    end

    // carry chains starting from the reset value of cf
    send_op(op_adc, mode_64, 64'd1, 64'd2, '0);
    send_op(op_add, mode_64, '1, 64'd1, '0);
    send_op(op_adc, mode_64, 64'd5, 64'd6, '0);
    send_op(op_add, mode_64, '1, '1, '0);
    send_op(op_adc, mode_64, '1, '1, '0);
    send_op(op_add, mode_64, 64'h7fff_ffff_ffff_ffff, 64'd1, '0);
    send_op(op_sub, mode_64, 64'd0, 64'd1, '0);
    send_op(op_sbb, mode_64, 64'd10, 64'd3, '0);
    send_op(op_sub, mode_64, '1, '1, '0);
    send_op(op_sbbi, mode_64, 64'h8000_0000_0000_0000, '0, 16'h0001);
    send_op(op_adci, mode_8, 64'hff, '0, 16'h0001);

    // cmp and test only touch flags, mov keeps them
    send_op(op_cmp, mode_32, 64'd5, 64'd5, '0);
    send_op(op_mov, mode_64, '0, 64'hdead_beef_0123_4567, '0);
    send_op(op_testi, mode_16, 64'h00f0, '0, 16'h0f0f);
    send_op(op_movi, mode_16, '0, '0, 16'h8001);
    send_op(op_cmpi, mode_8, 64'h10, '0, 16'h0020);
    send_op(op_test, mode_64, '1, 64'h8000_0000_0000_0000, '0);
    send_op(op_mov, mode_8, '0, 64'h1234, '0);
    drain;

    repeat (num_rand) send_random;
    drain;

    // back-pressure
    @(negedge clk);
    held_base = results_seen;
    @(posedge clk);
    hold_credits <= 1'b1;
    repeat (queue_depth + out_credits) send_random;
    op_valid <= 1'b0;
    repeat (20) @(posedge clk);
    @(negedge clk);
    held_n = results_seen - held_base;
    check_val("results while credits held", 64'(held_n), 64'(out_credits));
    @(posedge clk);
    hold_credits <= 1'b0;
    drain;

    @(negedge clk);
    check_val("op_credit pulses", 64'(credit_pulses), 64'(sent_cnt));
    $display("%0d results checked, %0d errors", results_seen, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- src.f
hdl/alu_pkg.sv
hdl/op_queue.sv
hdl/arith_unit.sv
hdl/logic_unit.sv
hdl/alu_core.sv
hdl/alu_top.sv
testbench/alu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/alu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
